/* source/conv_pkg.sv */
// package with data widths, kernel size, sign threshold and memory map constants
`default_nettype none

package conv_pkg;

	// memory port widths
	localparam int addr_w = 12;
	localparam int data_w = 16;

	// column index into one 16-bit input row
	localparam int col_w = 4;

	// kernel is fixed at 3x3, also the depth of the row window
	localparam int kernel_dim = 3;

	// negatives per kernel row (0..3) and over the whole kernel (0..9)
	localparam int count_w = 2;
	localparam int sum_w = 4;

	// at most this many negative products still gives a 1
	localparam logic [sum_w-1:0] neg_limit = sum_w'(4);

	// input memory map
	localparam logic [addr_w-1:0] rows_addr = addr_w'(0);
	localparam logic [addr_w-1:0] cols_addr = addr_w'(1);
	localparam logic [addr_w-1:0] first_row_addr = addr_w'(2);

	// weight memory, only the data word is read
	localparam logic [addr_w-1:0] weight_addr = addr_w'(1);

	// columns swept before the first full window
	localparam logic [col_w-1:0] col_lag = col_w'(kernel_dim - 1);
	// input rows covered by one window
	localparam logic [addr_w-1:0] row_span = addr_w'(kernel_dim);

endpackage

`default_nettype wire

/* source/conv_sequencer.sv */
// sequencer FSM with run/busy, size and weight fetch, row reads, column sweep and window tags
`timescale 1ns/10ps
`default_nettype none

module conv_sequencer (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic                        run,
	output logic                        busy,
	output logic [conv_pkg::addr_w-1:0] sram_read_address,
	input  logic [conv_pkg::data_w-1:0] sram_read_data,
	output logic [conv_pkg::addr_w-1:0] wmem_read_address,
	input  logic [conv_pkg::data_w-1:0] wmem_read_data,
	output logic                        row_load,
	output logic                        row_shift,
	output logic [conv_pkg::col_w-1:0]  col_idx,
	output logic                        col_valid,
	output logic                        weight_load,
	output logic [conv_pkg::kernel_dim*conv_pkg::kernel_dim-1:0] weights,
	output logic                        tag_valid,
	output logic [conv_pkg::col_w-1:0]  tag_col,
	output logic                        tag_last,
	output logic [conv_pkg::addr_w-1:0] tag_row
);

	typedef enum logic [2:0] {
		st_idle,
		st_size,
		st_weight,
		st_fill,
		st_sweep,
		st_next,
		st_finish
	} state_t;

	state_t state;

	// sub-step inside size fetch, row fill and drain
	logic [1:0] step;
	// next input row to read
	logic [conv_pkg::addr_w-1:0] rd_addr;
	// output row being swept
	logic [conv_pkg::addr_w-1:0] out_row;

	// image size captured once per run
	logic [conv_pkg::addr_w-1:0] num_rows;
	logic [conv_pkg::col_w-1:0] last_col;
	logic [conv_pkg::data_w-1:0] cols_m1;

	// youngest window row is the last input row
	logic last_row;

	assign cols_m1 = sram_read_data - 1'b1;
	assign last_row = (out_row + conv_pkg::row_span) == num_rows;

	// weights sit at a fixed address
	assign wmem_read_address = conv_pkg::weight_addr;
	assign weights = wmem_read_data[conv_pkg::kernel_dim*conv_pkg::kernel_dim-1:0];
	assign weight_load = (state == st_weight);

	// first fill cycle only loads, later ones push older rows up
	assign row_load = (state == st_fill) || (state == st_next);
	assign row_shift = ((state == st_fill) && (step != 2'd0)) || (state == st_next);

	assign col_valid = (state == st_sweep);

	// tag once three columns are in the units
	assign tag_valid = (state == st_sweep) && (col_idx >= conv_pkg::col_lag);
	assign tag_col = col_idx - conv_pkg::col_lag;
	assign tag_last = (col_idx == last_col);
	assign tag_row = out_row;

	always_comb begin
		sram_read_address = rd_addr;
		// rows first, then columns
		if (state == st_size) begin
			if (step == 2'd0) begin
				sram_read_address = conv_pkg::rows_addr;
			end else begin
				sram_read_address = conv_pkg::cols_addr;
			end
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= st_idle;
			busy <= 1'b0;
			step <= 2'd0;
			rd_addr <= conv_pkg::first_row_addr;
			out_row <= '0;
			col_idx <= '0;
		end else begin
			case (state)
				st_idle: begin
					// run only looked at here
					if (run) begin
						state <= st_size;
						busy <= 1'b1;
						step <= 2'd0;
						rd_addr <= conv_pkg::first_row_addr;
						out_row <= '0;
					end
				end
				st_size: begin
					step <= step + 1'b1;
					if (step == 2'd1) begin
						state <= st_weight;
					end
				end
				st_weight: begin
					// row 0 read goes out here
					rd_addr <= rd_addr + 1'b1;
					step <= 2'd0;
					state <= st_fill;
				end
				st_fill: begin
					step <= step + 1'b1;
					// no read past the third row yet
					if (step != 2'd2) begin
						rd_addr <= rd_addr + 1'b1;
					end else begin
						step <= 2'd0;
						col_idx <= '0;
						state <= st_sweep;
					end
				end
				st_sweep: begin
					if (col_idx == last_col) begin
						if (last_row) begin
							step <= 2'd0;
							state <= st_finish;
						end else begin
							state <= st_next;
						end
					end else begin
						col_idx <= col_idx + 1'b1;
					end
				end
				st_next: begin
					// next row lands this cycle
					rd_addr <= rd_addr + 1'b1;
					out_row <= out_row + 1'b1;
					col_idx <= '0;
					state <= st_sweep;
				end
				st_finish: begin
					// two pipe stages plus the write cycle
					step <= step + 1'b1;
					if (step == 2'd2) begin
						busy <= 1'b0;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
					busy <= 1'b0;
				end
			endcase
		end
	end

	// size registers
	always_ff @(posedge clk) begin
		if ((state == st_size) && (step == 2'd1)) begin
			num_rows <= sram_read_data[conv_pkg::addr_w-1:0];
		end
		if (state == st_weight) begin
			last_col <= cols_m1[conv_pkg::col_w-1:0];
		end
	end

	// run ends only after the final output row
	a_busy_fall: assert property (@(posedge clk) disable iff (!reset_b)
		$fell(busy) |-> last_row);

	// a sweep needs at least a full kernel width of columns
	a_col_valid: assert property (@(posedge clk) disable iff (!reset_b)
		col_valid |-> (last_col >= conv_pkg::col_lag));

endmodule

`default_nettype wire

/* source/row_window.sv */
// three-row input window with row shift and per-column bit select
`timescale 1ns/10ps
`default_nettype none

module row_window (
	input  logic                            clk,
	input  logic                            reset_b,
	input  logic                            row_load,
	input  logic                            row_shift,
	input  logic [conv_pkg::data_w-1:0]     new_row,
	input  logic [conv_pkg::col_w-1:0]      col_idx,
	output logic [conv_pkg::kernel_dim-1:0] col_bits
);

	// rows[0] oldest, top kernel row
	logic [conv_pkg::data_w-1:0] rows [conv_pkg::kernel_dim];

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			for (int i = 0; i < conv_pkg::kernel_dim; i++) begin
				rows[i] <= '0;
			end
		end else begin
			// move everything up one
			if (row_shift) begin
				for (int i = 0; i < conv_pkg::kernel_dim - 1; i++) begin
					rows[i] <= rows[i+1];
				end
			end
			// youngest slot takes the fresh word
			if (row_load) begin
				rows[conv_pkg::kernel_dim-1] <= new_row;
			end
		end
	end

	// same column from every row
	always_comb begin
		for (int i = 0; i < conv_pkg::kernel_dim; i++) begin
			col_bits[i] = rows[i][col_idx];
		end
	end

endmodule

`default_nettype wire

/* source/kernel_row_unit.sv */
// one kernel row with its weight bits, 3-column shift register and registered negative count
`timescale 1ns/10ps
`default_nettype none

module kernel_row_unit (
	input  logic                            clk,
	input  logic                            reset_b,
	input  logic                            weight_load,
	input  logic [conv_pkg::kernel_dim-1:0] weight_bits,
	input  logic                            col_valid,
	input  logic                            col_bit,
	output logic [conv_pkg::count_w-1:0]    neg_count
);

	logic [conv_pkg::kernel_dim-1:0] weight_q;
	// bit 0 holds the oldest column and pairs with weight 0
	logic [conv_pkg::kernel_dim-1:0] cols_q;
	// 1 where input and weight differ
	logic [conv_pkg::kernel_dim-1:0] neg;
	logic [conv_pkg::count_w-1:0] neg_sum;

	always_ff @(posedge clk) begin
		if (weight_load) begin
			weight_q <= weight_bits;
		end
		// newest column enters at the top
		if (col_valid) begin
			cols_q <= {col_bit, cols_q[conv_pkg::kernel_dim-1:1]};
		end
	end

	assign neg = cols_q ^ weight_q;

	// popcount of the mismatches
	always_comb begin
		neg_sum = '0;
		for (int j = 0; j < conv_pkg::kernel_dim; j++) begin
			neg_sum = neg_sum + {{(conv_pkg::count_w-1){1'b0}}, neg[j]};
		end
	end

	// one cycle after the shift
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			neg_count <= '0;
		end else begin
			neg_count <= neg_sum;
		end
	end

	// weights stay put while columns stream through
	a_weight_hold: assert property (@(posedge clk) disable iff (!reset_b)
		weight_load |-> !col_valid);

endmodule

`default_nettype wire

/* source/threshold_collector.sv */
// tag delay, count sum, sign threshold, output word assembly and write pulse
`timescale 1ns/10ps
`default_nettype none

module threshold_collector (
	input  logic                                                  clk,
	input  logic                                                  reset_b,
	input  logic [conv_pkg::kernel_dim-1:0][conv_pkg::count_w-1:0] counts,
	input  logic                                                  tag_valid,
	input  logic [conv_pkg::col_w-1:0]                            tag_col,
	input  logic                                                  tag_last,
	input  logic [conv_pkg::addr_w-1:0]                           tag_row,
	output logic [conv_pkg::addr_w-1:0]                           sram_write_address,
	output logic [conv_pkg::data_w-1:0]                           sram_write_data,
	output logic                                                  sram_write_enable
);

	// tag pipe, index 1 lines up with the unit counts
	logic [1:0] valid_pipe;
	logic [1:0] last_pipe;
	logic [conv_pkg::col_w-1:0] col_pipe [2];
	logic [conv_pkg::addr_w-1:0] row_pipe [2];

	// total negatives over the window
	logic [conv_pkg::sum_w-1:0] neg_total;
	logic out_bit;

	// row under assembly
	logic [conv_pkg::data_w-1:0] word;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			valid_pipe <= '0;
			last_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[0], tag_valid};
			last_pipe <= {last_pipe[0], tag_valid & tag_last};
		end
	end

	always_ff @(posedge clk) begin
		col_pipe[0] <= tag_col;
		col_pipe[1] <= col_pipe[0];
		row_pipe[0] <= tag_row;
		row_pipe[1] <= row_pipe[0];
	end

	always_comb begin
		neg_total = '0;
		for (int i = 0; i < conv_pkg::kernel_dim; i++) begin
			neg_total = neg_total
				+ {{(conv_pkg::sum_w-conv_pkg::count_w){1'b0}}, counts[i]};
		end
	end

	// +1 unless most products are negative
	assign out_bit = (neg_total <= conv_pkg::neg_limit);

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			word <= '0;
			sram_write_enable <= 1'b0;
		end else begin
			// pulse right after the last window of a row
			sram_write_enable <= valid_pipe[1] & last_pipe[1];
			if (sram_write_enable) begin
				// fresh word for the next row
				word <= '0;
			end else if (valid_pipe[1]) begin
				word[col_pipe[1]] <= out_bit;
			end
		end
	end

	// row address held for the write cycle
	always_ff @(posedge clk) begin
		if (valid_pipe[1] & last_pipe[1]) begin
			sram_write_address <= row_pipe[1];
		end
	end

	assign sram_write_data = word;

	// one write per output row, never back to back
	a_single_write: assert property (@(posedge clk) disable iff (!reset_b)
		sram_write_enable |=> !sram_write_enable);

endmodule

`default_nettype wire

/* source/conv_top.sv */
// top level: sequencer, row window, kernel row units and output collector
`timescale 1ns/10ps
`default_nettype none

module conv_top (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic                        run,
	output logic                        busy,
	output logic [conv_pkg::addr_w-1:0] sram_read_address,
	input  logic [conv_pkg::data_w-1:0] sram_read_data,
	output logic [conv_pkg::addr_w-1:0] wmem_read_address,
	input  logic [conv_pkg::data_w-1:0] wmem_read_data,
	output logic [conv_pkg::addr_w-1:0] sram_write_address,
	output logic [conv_pkg::data_w-1:0] sram_write_data,
	output logic                        sram_write_enable
);

	// window control
	logic row_load;
	logic row_shift;
	logic [conv_pkg::col_w-1:0] col_idx;
	logic [conv_pkg::kernel_dim-1:0] col_bits;

	// kernel unit control
	logic col_valid;
	logic weight_load;
	logic [conv_pkg::kernel_dim*conv_pkg::kernel_dim-1:0] weights;

	// window tag toward the collector
	logic tag_valid;
	logic [conv_pkg::col_w-1:0] tag_col;
	logic tag_last;
	logic [conv_pkg::addr_w-1:0] tag_row;

	// per kernel row negative counts
	logic [conv_pkg::kernel_dim-1:0][conv_pkg::count_w-1:0] counts;

	conv_sequencer u_seq (
		.clk               (clk),
		.reset_b           (reset_b),
		.run               (run),
		.busy              (busy),
		.sram_read_address (sram_read_address),
		.sram_read_data    (sram_read_data),
		.wmem_read_address (wmem_read_address),
		.wmem_read_data    (wmem_read_data),
		.row_load          (row_load),
		.row_shift         (row_shift),
		.col_idx           (col_idx),
		.col_valid         (col_valid),
		.weight_load       (weight_load),
		.weights           (weights),
		.tag_valid         (tag_valid),
		.tag_col           (tag_col),
		.tag_last          (tag_last),
		.tag_row           (tag_row)
	);

	// input rows come straight off the read port
	row_window u_window (
		.clk       (clk),
		.reset_b   (reset_b),
		.row_load  (row_load),
		.row_shift (row_shift),
		.new_row   (sram_read_data),
		.col_idx   (col_idx),
		.col_bits  (col_bits)
	);

	// unit i pairs weights 3i..3i+2 with window row i
	for (genvar i = 0; i < conv_pkg::kernel_dim; i++) begin : g_krow
		kernel_row_unit u_krow (
			.clk         (clk),
			.reset_b     (reset_b),
			.weight_load (weight_load),
			.weight_bits (weights[i*conv_pkg::kernel_dim +: conv_pkg::kernel_dim]),
			.col_valid   (col_valid),
			.col_bit     (col_bits[i]),
			.neg_count   (counts[i])
		);
	end

	threshold_collector u_collect (
		.clk                (clk),
		.reset_b            (reset_b),
		.counts             (counts),
		.tag_valid          (tag_valid),
		.tag_col            (tag_col),
		.tag_last           (tag_last),
		.tag_row            (tag_row),
		.sram_write_address (sram_write_address),
		.sram_write_data    (sram_write_data),
		.sram_write_enable  (sram_write_enable)
	);

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// testbench clock generator, 4 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk
);

	// half of the 4 ns period
	localparam real half_period = 2.0;

	initial begin
		clk = 1'b0;
		forever begin
			#(half_period) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* test/conv_tb.sv */
// testbench top: memory models, reference model, LFSR, directed tests, watchdog, summary
`timescale 1ns/10ps
`default_nettype none

module conv_tb;

	localparam int reset_cycles = 8;
	localparam int idle_cycles = 20;
	localparam int mem_depth = 4096;

	logic clk;
	logic reset_b;
	logic run;
	logic busy;
	logic [conv_pkg::addr_w-1:0] sram_read_address;
	logic [conv_pkg::data_w-1:0] sram_read_data;
	logic [conv_pkg::addr_w-1:0] wmem_read_address;
	logic [conv_pkg::data_w-1:0] wmem_read_data;
	logic [conv_pkg::addr_w-1:0] sram_write_address;
	logic [conv_pkg::data_w-1:0] sram_write_data;
	logic sram_write_enable;

	// input, weight and output memories
	logic [15:0] in_mem [mem_depth];
	logic [15:0] w_mem [mem_depth];
	logic [15:0] out_mem [mem_depth];
	logic [11:0] in_addr_q;
	logic [11:0] w_addr_q;

	// every write in arrival order
	logic [11:0] wr_addr_log [256];
	logic [15:0] wr_data_log [256];
	int wr_count;

	// image under test
	logic [15:0] img [16];
	int img_rows;
	int img_cols;
	logic [8:0] img_w;

	logic [31:0] lfsr_state;
	int checks;
	int errors;
	int tests_run;

	tb_clock clock_i (
		.clk (clk)
	);

	conv_top dut_i (
		.clk                (clk),
		.reset_b            (reset_b),
		.run                (run),
		.busy               (busy),
		.sram_read_address  (sram_read_address),
		.sram_read_data     (sram_read_data),
		.wmem_read_address  (wmem_read_address),
		.wmem_read_data     (wmem_read_data),
		.sram_write_address (sram_write_address),
		.sram_write_data    (sram_write_data),
		.sram_write_enable  (sram_write_enable)
	);

	// read ports, data for the previous cycle's address shows up mid-cycle
	initial begin
		sram_read_data = '0;
		wmem_read_data = '0;
		in_addr_q = '0;
		w_addr_q = '0;
		forever begin
			@(negedge clk);
			sram_read_data = in_mem[in_addr_q];
			wmem_read_data = w_mem[w_addr_q];
			in_addr_q = sram_read_address;
			w_addr_q = wmem_read_address;
		end
	end

	// write port, sampled away from the active edge
	initial begin
		wr_count = 0;
		forever begin
			@(negedge clk);
			if (sram_write_enable) begin
				out_mem[sram_write_address] = sram_write_data;
				wr_addr_log[8'(wr_count)] = sram_write_address;
				wr_data_log[8'(wr_count)] = sram_write_data;
				wr_count++;
			end
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// cycle budget of one run
	function automatic int run_cycles(input int rows, input int cols);
		return rows * (cols + 8) + 50;
	endfunction

	// reference: bit c set when at most four of the nine products are negative
	function automatic logic [15:0] model_word(input int r);
		logic [15:0] word;
		logic [15:0] row_bits;
		logic [8:0] w_bits;
		int neg;
		word = '0;
		for (int c = 0; c <= img_cols - 3; c++) begin
			neg = 0;
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					row_bits = img[4'(r + i)] >> (c + j);
					w_bits = img_w >> (3 * i + j);
					// differing signs give a negative product
					if (row_bits[0] != w_bits[0]) begin
						neg = neg + 1;
					end
				end
			end
			if (neg <= 4) begin
				word = word | (16'h1 << c);
			end
		end
		return word;
	endfunction

	task automatic check_equal(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("[FAIL] %s: got %h, expected %h", what, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			$display("%s", msg);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	// background pattern tied to every address bit
	task automatic fill_memories();
		for (int a = 0; a < mem_depth; a++) begin
			in_mem[12'(a)] = {4'h3, 12'(a)};
			w_mem[12'(a)] = {4'hc, 12'(a)};
		end
	endtask

	// whole 16-bit rows random, bits past cols must not leak
	task automatic make_random_image(input int rows, input int cols);
		img_rows = rows;
		img_cols = cols;
		img_w = 9'(take_bits(9));
		for (int k = 0; k < rows; k++) begin
			img[4'(k)] = take_bits(16);
		end
	endtask

	task automatic load_memories();
		logic [15:0] upper;
		in_mem[conv_pkg::rows_addr] = 16'(img_rows);
		in_mem[conv_pkg::cols_addr] = 16'(img_cols);
		for (int k = 0; k < img_rows; k++) begin
			in_mem[conv_pkg::first_row_addr + 12'(k)] = img[4'(k)];
		end
		// unused weight bits random
		upper = take_bits(7);
		w_mem[conv_pkg::weight_addr] = {upper[6:0], img_w};
	endtask

	// load, raise run until busy answers, then wait for busy to drop
	task automatic start_run(output int first_wr);
		int waited;
		int limit;
		load_memories();
		first_wr = wr_count;
		limit = run_cycles(img_rows, img_cols);
		run = 1'b1;
		waited = 0;
		while (!busy && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		run = 1'b0;
		check_true(busy, "busy did not rise after run was raised");
		waited = 0;
		while (busy && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		check_true(!busy, $sformatf("busy still high %0d cycles into the run", limit));
	endtask

	// one write per output row, in order, matching the model
	task automatic check_outputs(input int first_wr);
		int n_out;
		int idx;
		logic [15:0] exp;
		n_out = img_rows - 2;
		check_true(wr_count - first_wr == n_out,
			$sformatf("expected %0d writes, saw %0d", n_out, wr_count - first_wr));
		for (int r = 0; r < n_out; r++) begin
			exp = model_word(r);
			idx = first_wr + r;
			if (idx < wr_count) begin
				check_equal("sram_write_address", 16'(wr_addr_log[8'(idx)]), 16'(r));
				check_equal("sram_write_data", wr_data_log[8'(idx)], exp);
			end
			check_equal("output memory word", out_mem[12'(r)], exp);
		end
	endtask

	task automatic test_reset_idle();
		int errs;
		int first;
		errs = errors;
		first = wr_count;
		check_equal("busy", 16'(busy), 16'h0);
		check_equal("sram_write_enable", 16'(sram_write_enable), 16'h0);
		// run stays low, nothing may move
		repeat (idle_cycles) begin
			@(negedge clk);
			check_true(!busy && !sram_write_enable, "activity seen while run is low");
		end
		check_true(wr_count == first, "memory written without run");
		report_test("reset_idle", errs);
	endtask

	task automatic test_zero_image();
		int errs;
		int first;
		errs = errors;
		img_rows = 3;
		img_cols = 3;
		img_w = '0;
		for (int k = 0; k < 3; k++) begin
			img[4'(k)] = '0;
		end
		start_run(first);
		check_outputs(first);
		// all products positive, single output bit
		check_equal("sram_write_address", 16'(wr_addr_log[8'(first)]), 16'h0000);
		check_equal("sram_write_data", wr_data_log[8'(first)], 16'h0001);
		report_test("zero_image", errs);
	endtask

	task automatic test_random(input string name, input int rows, input int cols);
		int errs;
		int first;
		errs = errors;
		make_random_image(rows, cols);
		start_run(first);
		check_outputs(first);
		report_test(name, errs);
	endtask

	// single window, every input bit against its weight
	task automatic test_complement();
		int errs;
		int first;
		logic [15:0] tmp;
		errs = errors;
		repeat (4) begin
			img_rows = 3;
			img_cols = 3;
			img_w = 9'(take_bits(9));
			tmp = take_bits(16);
			img[0] = {tmp[15:3], ~img_w[2:0]};
			tmp = take_bits(16);
			img[1] = {tmp[15:3], ~img_w[5:3]};
			tmp = take_bits(16);
			img[2] = {tmp[15:3], ~img_w[8:6]};
			start_run(first);
			check_outputs(first);
			check_equal("sram_write_data", wr_data_log[8'(first)], 16'h0000);
		end
		report_test("complement", errs);
	endtask

	// second run starts right after busy drops, same output rows
	task automatic test_back_to_back();
		int errs;
		int first;
		errs = errors;
		make_random_image(5, 12);
		start_run(first);
		check_outputs(first);
		make_random_image(5, 6);
		start_run(first);
		check_outputs(first);
		report_test("back_to_back", errs);
	endtask

	// sum of the run budgets plus reset and idle time
	initial begin
		int limit;
		limit = reset_cycles + idle_cycles + 16
			+ run_cycles(3, 3) + run_cycles(5, 8) + run_cycles(16, 16)
			+ 4 * run_cycles(3, 3) + run_cycles(5, 12) + run_cycles(5, 6);
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", limit);
		$display("sim failed");
		$finish;
	end

	initial begin
		run = 1'b0;
		reset_b = 1'b0;
		lfsr_state = 32'hf78b_bf2b;
		checks = 0;
		errors = 0;
		tests_run = 0;
		fill_memories();
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset_b = 1'b1;
		@(negedge clk);
		test_reset_idle();
		test_zero_image();
		test_random("random_5x8", 5, 8);
		test_random("random_16x16", 16, 16);
		test_complement();
		test_back_to_back();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
source/conv_pkg.sv
source/conv_sequencer.sv
source/row_window.sv
source/kernel_row_unit.sv
source/threshold_collector.sv
source/conv_top.sv
test/tb_clock.sv
test/conv_tb.sv

/* run.sh */
#!/bin/sh
# build the convolution testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module conv_tb \
	-Mdir obj_dir -o conv_sim

out=$(./obj_dir/conv_sim)
echo "$out"

# exit status of the script is the result of this search
echo "$out" | grep -qx "sim passed"
